// ==== design/raster_defines.svh ====
`ifndef RASTER_DEFINES_SVH
`define RASTER_DEFINES_SVH

// fixed point word, Q16.16
`define RASTER_FIX_W 32
`define RASTER_FIX_FRAC 16

// opaque per-triangle metadata
`define RASTER_META_W 16

// entries in the input triangle queue
`define RASTER_QUEUE_DEPTH 4

// byte address into the register block
`define RASTER_APB_AW 4

`endif

// ==== design/raster_pkg.sv ====
`include "raster_defines.svh"

package raster_pkg;

    typedef logic signed [`RASTER_FIX_W-1:0] fixed_t;  // signed Q16.16

    typedef struct packed {
        fixed_t x;
        fixed_t y;
        fixed_t z;
    } position_t;

    typedef struct packed {
        position_t position;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef logic [`RASTER_META_W-1:0] triangle_meta_t;

    // one queue entry, everything the culler needs for one triangle
    typedef struct packed {
        triangle_t      triangle;
        logic           keep;  // pass culled faces on as zeroed triangles
        triangle_meta_t meta;
    } cull_in_t;

    typedef struct packed {
        logic cull_front;  // ctrl bit1
        logic cull_en;     // ctrl bit0
    } cull_cfg_t;

    typedef struct packed {
        logic culled;
        logic passed;
    } cull_event_t;

    typedef struct packed {
        logic                     psel;
        logic                     penable;
        logic                     pwrite;
        logic [`RASTER_APB_AW-1:0] paddr;
        logic [31:0]              pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    typedef enum logic [2:0] {
        IDLE,
        PROCESS_1,
        PROCESS_2,
        PROCESS_3,
        PROCESS_4,
        DONE
    } cull_state_t;

    typedef enum logic [`RASTER_APB_AW-1:0] {
        REG_CTRL   = 'h0,
        REG_CULLED = 'h4,
        REG_PASSED = 'h8
    } cull_reg_t;

    function automatic fixed_t fix_add(fixed_t a, fixed_t b);
        return a + b;  // wraps on overflow
    endfunction

    function automatic fixed_t fix_sub(fixed_t a, fixed_t b);
        return a - b;
    endfunction

    // full product, then arithmetic shift rounds toward minus infinity
    function automatic fixed_t fix_mul(fixed_t a, fixed_t b);
        logic signed [2*`RASTER_FIX_W-1:0] prod;
        prod = a * b;
        return fixed_t'(prod >>> `RASTER_FIX_FRAC);
    endfunction

endpackage

// ==== design/tri_queue.sv ====
`include "raster_defines.svh"

module tri_queue #(
    parameter int DEPTH = `RASTER_QUEUE_DEPTH  // power of two, at least 2
) (
    input  logic                clk,
    input  logic                rstn,
    input  logic                s_valid,
    output logic                s_ready,
    input  raster_pkg::cull_in_t s_data,
    output logic                m_valid,
    input  logic                m_ready,
    output raster_pkg::cull_in_t m_data
);
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    raster_pkg::cull_in_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign s_ready = (count != CNT_W'(DEPTH));  // room for one more
    assign m_valid = (count != '0);
    assign push    = s_valid && s_ready;
    assign pop     = m_valid && m_ready;
    assign m_data  = mem[rd_ptr];  // head is held until popped

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= s_data;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // natural wrap at DEPTH
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // idle, or push and pop together
            endcase
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rstn)
        count <= CNT_W'(DEPTH)
    ) else $error("tri_queue occupancy above DEPTH");

endmodule

// ==== design/backface_culler.sv ====
module backface_culler (
    input  logic                      clk,
    input  logic                      rstn,
    input  raster_pkg::cull_cfg_t     cfg,
    input  logic                      s_valid,
    output logic                      s_ready,
    input  raster_pkg::cull_in_t      s_data,
    output logic                      m_valid,
    input  logic                      m_ready,
    output raster_pkg::triangle_t     m_tri,
    output raster_pkg::triangle_meta_t m_meta,
    output raster_pkg::cull_event_t   evt
);
    function automatic raster_pkg::position_t sub3(raster_pkg::position_t a,
                                                   raster_pkg::position_t b);
        raster_pkg::position_t c;
        c.x = raster_pkg::fix_sub(a.x, b.x);
        c.y = raster_pkg::fix_sub(a.y, b.y);
        c.z = raster_pkg::fix_sub(a.z, b.z);
        return c;
    endfunction

    function automatic raster_pkg::position_t cross3(raster_pkg::position_t a,
                                                     raster_pkg::position_t b);
        raster_pkg::position_t c;
        c.x = raster_pkg::fix_sub(raster_pkg::fix_mul(a.y, b.z), raster_pkg::fix_mul(a.z, b.y));
        c.y = raster_pkg::fix_sub(raster_pkg::fix_mul(a.z, b.x), raster_pkg::fix_mul(a.x, b.z));
        c.z = raster_pkg::fix_sub(raster_pkg::fix_mul(a.x, b.y), raster_pkg::fix_mul(a.y, b.x));
        return c;
    endfunction

    function automatic raster_pkg::fixed_t dot3(raster_pkg::position_t a,
                                                raster_pkg::position_t b);
        raster_pkg::fixed_t xy;
        xy = raster_pkg::fix_add(raster_pkg::fix_mul(a.x, b.x), raster_pkg::fix_mul(a.y, b.y));
        return raster_pkg::fix_add(xy, raster_pkg::fix_mul(a.z, b.z));
    endfunction

    raster_pkg::cull_state_t    state;
    raster_pkg::cull_state_t    state_next;
    raster_pkg::triangle_t      tri_q;
    logic                       keep_q;
    raster_pkg::triangle_meta_t meta_q;
    raster_pkg::cull_cfg_t      cfg_q;
    raster_pkg::position_t      u_q;    // v1 - v0
    raster_pkg::position_t      v_q;    // v2 - v0
    raster_pkg::position_t      n_q;    // face normal
    raster_pkg::fixed_t         dot_q;  // n . v0
    logic                       accept;
    logic                       faces_culled;

    assign accept  = s_valid && s_ready;
    assign s_ready = (state == raster_pkg::IDLE);
    assign m_valid = (state == raster_pkg::DONE);

    // dot of exactly zero is edge-on and never culled
    assign faces_culled = cfg_q.cull_en &&
                          (cfg_q.cull_front ? (dot_q > 0) : (dot_q < 0));

    // one datapath step per process state
    always_ff @(posedge clk) begin
        if (accept) begin
            tri_q  <= s_data.triangle;
            keep_q <= s_data.keep;
            meta_q <= s_data.meta;
            cfg_q  <= cfg;  // config follows the triangle
        end
        case (state)
            raster_pkg::PROCESS_1: begin
                u_q <= sub3(tri_q.v1.position, tri_q.v0.position);
                v_q <= sub3(tri_q.v2.position, tri_q.v0.position);
            end
            raster_pkg::PROCESS_2: n_q <= cross3(u_q, v_q);
            raster_pkg::PROCESS_3: dot_q <= dot3(n_q, tri_q.v0.position);
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            raster_pkg::IDLE:      if (accept) state_next = raster_pkg::PROCESS_1;
            raster_pkg::PROCESS_1: state_next = raster_pkg::PROCESS_2;
            raster_pkg::PROCESS_2: state_next = raster_pkg::PROCESS_3;
            raster_pkg::PROCESS_3: state_next = raster_pkg::PROCESS_4;
            raster_pkg::PROCESS_4: begin
                // culled and not kept: drop without output
                if (faces_culled && !keep_q) begin
                    state_next = raster_pkg::IDLE;
                end else begin
                    state_next = raster_pkg::DONE;
                end
            end
            raster_pkg::DONE:      if (m_ready) state_next = raster_pkg::IDLE;
            default:               state_next = raster_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= raster_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign evt.culled = (state == raster_pkg::PROCESS_4) && faces_culled;
    assign evt.passed = (state == raster_pkg::PROCESS_4) && !faces_culled;

    // kept culled faces go out zeroed, metadata untouched
    assign m_tri  = faces_culled ? '0 : tri_q;
    assign m_meta = meta_q;

    a_no_overlap: assert property (
        @(posedge clk) disable iff (!rstn)
        !(m_valid && s_ready)
    ) else $error("culler offers output while accepting");

    a_one_event: assert property (
        @(posedge clk) disable iff (!rstn)
        accept |-> ##4 $onehot({evt.culled, evt.passed})
    ) else $error("accepted triangle without exactly one event");

    a_out_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        m_valid && !m_ready |=> m_valid && $stable(m_tri) && $stable(m_meta)
    ) else $error("output changed under back-pressure");

endmodule

// ==== design/cull_regs.sv ====
module cull_regs (
    input  logic                    clk,
    input  logic                    rstn,
    input  raster_pkg::apb_req_t    apb_req,
    output raster_pkg::apb_rsp_t    apb_rsp,
    output raster_pkg::cull_cfg_t   cfg,
    input  raster_pkg::cull_event_t evt
);
    raster_pkg::cull_cfg_t ctrl_q;
    logic [31:0]           culled_cnt;
    logic [31:0]           passed_cnt;
    logic [31:0]           rdata;
    logic                  wr_en;
    logic                  mapped;
    logic                  clr_cnt;

    assign wr_en = apb_req.psel && apb_req.penable && apb_req.pwrite;

    always_comb begin
        mapped  = 1'b1;
        clr_cnt = 1'b0;
        rdata   = '0;
        case (apb_req.paddr)
            raster_pkg::REG_CTRL: rdata = {30'd0, ctrl_q};
            raster_pkg::REG_CULLED: begin
                rdata   = culled_cnt;
                clr_cnt = wr_en;
            end
            raster_pkg::REG_PASSED: begin
                rdata   = passed_cnt;
                clr_cnt = wr_en;
            end
            default: mapped = 1'b0;  // reads zero
        endcase
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            ctrl_q <= '{cull_front: 1'b0, cull_en: 1'b1};  // back-face culling on
        end else if (wr_en && apb_req.paddr == raster_pkg::REG_CTRL) begin
            ctrl_q <= raster_pkg::cull_cfg_t'(apb_req.pwdata[1:0]);
        end
    end

    // a write to either counter clears both, data ignored
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            culled_cnt <= '0;
            passed_cnt <= '0;
        end else if (clr_cnt) begin
            culled_cnt <= '0;
            passed_cnt <= '0;
        end else begin
            if (evt.culled && culled_cnt != '1) begin
                culled_cnt <= culled_cnt + 1'b1;  // saturates at all ones
            end
            if (evt.passed && passed_cnt != '1) begin
                passed_cnt <= passed_cnt + 1'b1;
            end
        end
    end

    assign cfg = ctrl_q;

    always_comb begin
        apb_rsp.prdata  = rdata;
        apb_rsp.pready  = 1'b1;  // no wait states
        apb_rsp.pslverr = apb_req.psel && apb_req.penable && !mapped;
    end

    a_penable_psel: assert property (
        @(posedge clk) disable iff (!rstn)
        apb_req.penable |-> apb_req.psel
    ) else $error("penable without psel");

endmodule

// ==== design/raster_cull.sv ====
module raster_cull (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       in_valid,
    output logic                       in_ready,
    input  raster_pkg::cull_in_t       in_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output raster_pkg::triangle_t      out_tri,
    output raster_pkg::triangle_meta_t out_meta,
    input  raster_pkg::apb_req_t       apb_req,
    output raster_pkg::apb_rsp_t       apb_rsp
);
    logic                    q_valid;  // queue head to culler
    logic                    q_ready;
    raster_pkg::cull_in_t    q_data;
    raster_pkg::cull_cfg_t   cfg;
    raster_pkg::cull_event_t evt;

    tri_queue u_queue (
        .clk     (clk),
        .rstn    (rstn),
        .s_valid (in_valid),
        .s_ready (in_ready),
        .s_data  (in_data),
        .m_valid (q_valid),
        .m_ready (q_ready),
        .m_data  (q_data)
    );

    backface_culler u_culler (
        .clk     (clk),
        .rstn    (rstn),
        .cfg     (cfg),
        .s_valid (q_valid),
        .s_ready (q_ready),
        .s_data  (q_data),
        .m_valid (out_valid),
        .m_ready (out_ready),
        .m_tri   (out_tri),
        .m_meta  (out_meta),
        .evt     (evt)
    );

    cull_regs u_regs (
        .clk     (clk),
        .rstn    (rstn),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .cfg     (cfg),
        .evt     (evt)
    );

endmodule

// ==== verif/raster_cull_tb_ref.svh ====
`ifndef RASTER_CULL_TB_REF_SVH
`define RASTER_CULL_TB_REF_SVH

logic [31:0] lcg_state = 32'h526f40b3;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// top 20 bits as a signed Q16.16 value, range -8.0 up to just below 8.0
function automatic raster_pkg::fixed_t rand_coord();
    logic [31:0] r;
    r = lcg_next();
    return {{12{r[31]}}, r[31:12]};
endfunction

function automatic raster_pkg::position_t rand_pos();
    raster_pkg::position_t p;
    p.x = rand_coord();
    p.y = rand_coord();
    p.z = rand_coord();
    return p;
endfunction

function automatic raster_pkg::cull_in_t make_tri(input bit rand_keep);
    raster_pkg::cull_in_t item;
    logic [31:0] r;
    item.triangle.v0.position = rand_pos();
    item.triangle.v1.position = rand_pos();
    item.triangle.v2.position = rand_pos();
    r = lcg_next();
    item.keep = rand_keep ? r[9] : 1'b0;
    item.meta = r[31:16];
    return item;
endfunction

// returns 0 when dropped, 1 when sent out zeroed, 2 when sent out unchanged
function automatic int ref_cull(input raster_pkg::cull_in_t item, input logic [1:0] ctrl,
                                output raster_pkg::cull_in_t res);
    raster_pkg::position_t a;
    raster_pkg::position_t b;
    raster_pkg::position_t c;
    raster_pkg::fixed_t ux, uy, uz, wx, wy, wz, nx, ny, nz, d;
    logic hit;
    a = item.triangle.v0.position;
    b = item.triangle.v1.position;
    c = item.triangle.v2.position;
    ux = raster_pkg::fix_sub(b.x, a.x);
    uy = raster_pkg::fix_sub(b.y, a.y);
    uz = raster_pkg::fix_sub(b.z, a.z);
    wx = raster_pkg::fix_sub(c.x, a.x);
    wy = raster_pkg::fix_sub(c.y, a.y);
    wz = raster_pkg::fix_sub(c.z, a.z);
    nx = raster_pkg::fix_sub(raster_pkg::fix_mul(uy, wz), raster_pkg::fix_mul(uz, wy));
    ny = raster_pkg::fix_sub(raster_pkg::fix_mul(uz, wx), raster_pkg::fix_mul(ux, wz));
    nz = raster_pkg::fix_sub(raster_pkg::fix_mul(ux, wy), raster_pkg::fix_mul(uy, wx));
    d = raster_pkg::fix_add(raster_pkg::fix_mul(nz, a.z),
                            raster_pkg::fix_add(raster_pkg::fix_mul(nx, a.x),
                                                raster_pkg::fix_mul(ny, a.y)));
    hit = ctrl[0] && (ctrl[1] ? (d > 0) : (d < 0));  // zero never culled
    res = item;
    if (!hit) begin
        return 2;
    end
    res.triangle = '0;
    return item.keep ? 1 : 0;
endfunction

`endif

// ==== verif/raster_cull_tb.sv ====
`include "raster_defines.svh"

module raster_cull_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_TRIS = 200;  // sum of all batches below

    logic                       clk;
    logic                       rstn;
    logic                       in_valid;
    logic                       in_ready;
    raster_pkg::cull_in_t       in_data;
    logic                       out_valid;
    logic                       out_ready;
    raster_pkg::triangle_t      out_tri;
    raster_pkg::triangle_meta_t out_meta;
    raster_pkg::apb_req_t       apb_req;
    raster_pkg::apb_rsp_t       apb_rsp;

    raster_pkg::cull_in_t exp_q[$];  // outputs still owed, in input order
    logic [1:0] ctrl_shadow = 2'b01;
    int         tally_culled = 0;
    int         tally_passed = 0;
    int         errors = 0;
    int         checks = 0;
    logic       saw_full = 1'b0;

    `include "raster_cull_tb_ref.svh"

    raster_cull dut (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_tri   (out_tri),
        .out_meta  (out_meta),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s expected %h got %h", name, exp, got);
        end
    endtask

    // all bus tasks start 1 ns after a rising edge
    task automatic apb_read(input logic [`RASTER_APB_AW-1:0] addr, output logic [31:0] data,
                            output logic err);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk);
        #1 apb_req.penable = 1'b1;
        @(posedge clk);
        data = apb_rsp.prdata;  // access phase edge
        err  = apb_rsp.pslverr;
        check_val("pready", 32'h1, {31'd0, apb_rsp.pready});
        #1 apb_req = '0;
    endtask

    task automatic apb_write(input logic [`RASTER_APB_AW-1:0] addr, input logic [31:0] data);
        apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        #1 apb_req.penable = 1'b1;
        @(posedge clk);
        check_val("pready", 32'h1, {31'd0, apb_rsp.pready});
        #1 apb_req = '0;
    endtask

    task automatic set_ctrl(input logic [1:0] value);
        apb_write(raster_pkg::REG_CTRL, {30'd0, value});
        ctrl_shadow = value;
    endtask

    task automatic send_batch(input int n, input bit rand_keep, input bit bp);
        raster_pkg::cull_in_t item;
        raster_pkg::cull_in_t res;
        int                   outcome;
        logic                 taken;
        logic [31:0]          r;
        for (int i = 0; i < n; i++) begin
            item     = make_tri(rand_keep);
            in_data  = item;
            in_valid = 1'b1;
            taken    = 1'b0;
            while (!taken) begin
                @(posedge clk);
                taken = in_ready;
                if (!in_ready) saw_full = 1'b1;
                #1;
                if (bp) begin
                    r = lcg_next();
                    out_ready = r[20];  // random stall on the output
                end
            end
            outcome = ref_cull(item, ctrl_shadow, res);
            if (outcome == 2) tally_passed++;
            else tally_culled++;
            if (outcome != 0) exp_q.push_back(res);
        end
        in_valid = 1'b0;
    endtask

    // every accepted triangle must have its event and its output by the end
    task automatic drain();
        logic [31:0] c;
        logic [31:0] p;
        logic        err;
        int          polls;
        c = '0;
        p = '0;
        polls = 0;
        out_ready = 1'b1;
        while (c + p != tally_culled + tally_passed && polls < 100) begin
            apb_read(raster_pkg::REG_CULLED, c, err);
            apb_read(raster_pkg::REG_PASSED, p, err);
            polls++;
        end
        if (c + p != tally_culled + tally_passed) begin
            errors++;
            $display("culler events still missing for accepted triangles after draining");
        end
        check_val("expected queue size", 32'h0, exp_q.size());
    endtask

    always @(posedge clk) begin : check_out
        raster_pkg::cull_in_t exp_item;
        if (rstn && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("output triangle arrived with nothing expected, meta %h", out_meta);
            end else begin
                exp_item = exp_q.pop_front();
                checks++;
                if (out_tri !== exp_item.triangle) begin
                    errors++;
                    $display("Mismatch out_tri expected %h got %h", exp_item.triangle, out_tri);
                end
                if (out_meta !== exp_item.meta) begin
                    errors++;
                    $display("Mismatch out_meta expected %h got %h", exp_item.meta, out_meta);
                end
            end
        end
    end

    initial begin
        repeat (NUM_TRIS * 40 + 2000) @(posedge clk);
        errors++;
        $display("watchdog expired before the test sequence finished");
        $display("summary: %0d checks, %0d errors", checks, errors);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main
        logic [31:0] rd;
        logic        err;
        in_valid  = 1'b0;
        in_data   = '0;
        out_ready = 1'b1;
        apb_req   = '0;
        rstn      = 1'b0;
        repeat (16) @(posedge clk);
        #1 rstn = 1'b1;
        @(posedge clk);
        check_val("in_ready", 32'h1, {31'd0, in_ready});
        check_val("out_valid", 32'h0, {31'd0, out_valid});
        #1;
        apb_read(raster_pkg::REG_CTRL, rd, err);
        check_val("prdata CTRL", 32'h1, rd);

        send_batch(40, 1'b0, 1'b0);  // back faces dropped
        send_batch(40, 1'b1, 1'b0);  // keep flag zeroes them instead
        drain();
        set_ctrl(2'b11);              // front faces
        send_batch(30, 1'b0, 1'b0);
        drain();
        set_ctrl(2'b00);              // culling off
        send_batch(30, 1'b0, 1'b0);
        drain();
        set_ctrl(2'b01);
        saw_full = 1'b0;
        send_batch(60, 1'b1, 1'b1);
        drain();
        if (!saw_full) begin
            errors++;
            $display("in_ready never dropped while the input was held full");
        end

        apb_read(raster_pkg::REG_CULLED, rd, err);
        check_val("prdata CULLED", tally_culled, rd);
        apb_read(raster_pkg::REG_PASSED, rd, err);
        check_val("prdata PASSED", tally_passed, rd);
        apb_write(raster_pkg::REG_CULLED, 32'h0);  // clears both counters
        tally_culled = 0;
        tally_passed = 0;
        apb_read(raster_pkg::REG_CULLED, rd, err);
        check_val("prdata CULLED", 32'h0, rd);
        apb_read(raster_pkg::REG_PASSED, rd, err);
        check_val("prdata PASSED", 32'h0, rd);
        apb_read(4'hC, rd, err);
        check_val("pslverr", 32'h1, {31'd0, err});
        check_val("prdata unmapped", 32'h0, rd);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== raster_cull.f ====
+incdir+design
+incdir+verif
design/raster_pkg.sv
design/tri_queue.sv
design/backface_culler.sv
design/cull_regs.sv
design/raster_cull.sv
verif/raster_cull_tb.sv
